// File: files.f
+incdir+.
lpif_pkg.sv
ll_auto_sync.sv
lpif_field_pack.sv
lpif_field_unpack.sv
lpif_lane_map.sv
lpif_txrx_x2_slave_top.sv
tb_clk_gen.sv
tb_lpif_top.sv

// File: ll_auto_sync.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Link bring-up sequencing
// Online delays, auto strobe and marker bits
////////////////////////////////////////
module ll_auto_sync
  import lpif_pkg::*;
(
  input  logic       clk_wr,
  input  logic       rst_n,
  input  logic       tx_online,
  input  logic       rx_online,
  input  beat_mask_t tx_mrk_userbit,
  input  logic       tx_stb_userbit,
  input  delay_cnt_t delay_x_value,
  input  delay_cnt_t delay_y_value,
  input  delay_cnt_t delay_z_value,
  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output beat_mask_t tx_auto_mrk_userbit,
  output logic       tx_auto_stb_userbit
);

  // Counter slots
  localparam int CNT_TX_Z = 0;
  localparam int CNT_TX_Y = 1;
  localparam int CNT_RX_X = 2;
  localparam int NUM_CNT  = 3;

  logic       cnt_in   [NUM_CNT];
  delay_cnt_t cnt_lim  [NUM_CNT];
  delay_cnt_t cnt_q    [NUM_CNT];
  logic       cnt_done [NUM_CNT];

  ////////////////////////////////////////
  // Counter inputs and limits

  always_comb begin
    // Payload gate on tx side
    cnt_in[CNT_TX_Z]  = tx_online;
    cnt_lim[CNT_TX_Z] = delay_z_value;
    // Strobe gate, also tx side
    cnt_in[CNT_TX_Y]  = tx_online;
    cnt_lim[CNT_TX_Y] = delay_y_value;
    // Receive gate
    cnt_in[CNT_RX_X]  = rx_online;
    cnt_lim[CNT_RX_X] = delay_x_value;
  end

  ////////////////////////////////////////
  // Saturating delay counters

  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < NUM_CNT; i++) begin
      // Restart whenever the level drops
      if (!rst_n || !cnt_in[i]) begin
        cnt_q[i] <= '0;
      end else if (cnt_q[i] != '1) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  // Zero delay passes the level through same cycle
  always_comb begin
    for (int i = 0; i < NUM_CNT; i++) begin
      cnt_done[i] = cnt_in[i] && (cnt_q[i] >= cnt_lim[i]);
    end
  end

  ////////////////////////////////////////
  // Outputs

  assign tx_online_delay = cnt_done[CNT_TX_Z];
  assign rx_online_delay = cnt_done[CNT_RX_X];

  // Persistent strobe once the y delay has run out
  assign tx_auto_stb_userbit = cnt_done[CNT_TX_Y] & tx_stb_userbit;

  // Markers go out first, as soon as tx is online
  assign tx_auto_mrk_userbit = tx_online ? tx_mrk_userbit : '0;

endmodule

// File: lpif_consts.svh
////////////////////////////////////////
// Width and bit-position constants for
// the x2 half slave logic link
////////////////////////////////////////
`ifndef LPIF_CONSTS_SVH
`define LPIF_CONSTS_SVH

// User field widths
`define LPIF_DATA_W         128
`define LPIF_STATE_W        8
`define LPIF_PROTID_W       4
`define LPIF_CRC_W          16

// Half-beats per transfer, one bit each in valid masks
`define LPIF_BEAT_W         2

// Packed link word, sum of all user fields
`define LPIF_WORD_W         162

// One PHY channel, strobe + payload + marker
`define LPIF_PHY_W          83
`define LPIF_LANE_PAYLOAD_W 81
`define LPIF_STB_BIT        0
`define LPIF_MRK_BIT        82

// Bring-up delay values and counters
`define LPIF_DELAY_W        16

`endif

// File: lpif_field_pack.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Upstream field packing
// User fields into one transmit link word
////////////////////////////////////////
`include "lpif_consts.svh"

module lpif_field_pack
  import lpif_pkg::*;
(
  input  lpif_state_t               ustrm_state,
  input  logic [`LPIF_PROTID_W-1:0] ustrm_protid,
  input  lpif_data_t                ustrm_data,
  input  beat_mask_t                ustrm_dvalid,
  input  lpif_crc_t                 ustrm_crc,
  input  beat_mask_t                ustrm_crc_valid,
  input  beat_mask_t                ustrm_valid,
  input  logic                      m_gen2_mode,
  output link_word_t                tx_word
);

  // Gen1 runs on the lower data half only
  localparam int HALF_W = `LPIF_DATA_W / 2;

  lpif_data_t data_keep;
  beat_mask_t beat_keep;

  lpif_data_t data_m;
  beat_mask_t dvalid_m;
  beat_mask_t crc_valid_m;
  beat_mask_t valid_m;

  ////////////////////////////////////////
  // Gen1 masking

  // Full width in gen2
  assign data_keep = m_gen2_mode ? '1 : lpif_data_t'({HALF_W{1'b1}});

  // Gen1 keeps half-beat 0 only
  assign beat_keep = m_gen2_mode ? '1 : beat_mask_t'(1);

  assign data_m      = ustrm_data & data_keep;
  assign dvalid_m    = ustrm_dvalid & beat_keep;
  assign crc_valid_m = ustrm_crc_valid & beat_keep;
  assign valid_m     = ustrm_valid & beat_keep;

  ////////////////////////////////////////
  // Word assembly

  // Low to high: valid, crc_valid, crc, dvalid, data, protid, state
  assign tx_word = {
    ustrm_state,
    ustrm_protid,
    data_m,
    dvalid_m,
    ustrm_crc,
    crc_valid_m,
    valid_m
  };

endmodule

// File: lpif_field_unpack.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Downstream field unpacking
// Receive link word to user fields
////////////////////////////////////////
`include "lpif_consts.svh"

module lpif_field_unpack
  import lpif_pkg::*;
(
  input  link_word_t                rx_word,
  input  logic                      rx_online_delay,
  input  logic                      m_gen2_mode,
  output lpif_state_t               dstrm_state,
  output logic [`LPIF_PROTID_W-1:0] dstrm_protid,
  output lpif_data_t                dstrm_data,
  output beat_mask_t                dstrm_dvalid,
  output lpif_crc_t                 dstrm_crc,
  output beat_mask_t                dstrm_crc_valid,
  output beat_mask_t                dstrm_valid
);

  // Field offsets in the link word
  localparam int POS_VALID     = 0;
  localparam int POS_CRC_VALID = POS_VALID + `LPIF_BEAT_W;
  localparam int POS_CRC       = POS_CRC_VALID + `LPIF_BEAT_W;
  localparam int POS_DVALID    = POS_CRC + `LPIF_CRC_W;
  localparam int POS_DATA      = POS_DVALID + `LPIF_BEAT_W;
  localparam int POS_PROTID    = POS_DATA + `LPIF_DATA_W;
  localparam int POS_STATE     = POS_PROTID + `LPIF_PROTID_W;

  localparam int HALF_W = `LPIF_DATA_W / 2;

  lpif_data_t data_keep;
  beat_mask_t beat_keep;
  beat_mask_t beat_gate;

  ////////////////////////////////////////
  // Masks

  // Far end may send junk in the upper half in gen1
  assign data_keep = m_gen2_mode ? '1 : lpif_data_t'({HALF_W{1'b1}});
  assign beat_keep = m_gen2_mode ? '1 : beat_mask_t'(1);

  // Nothing is valid before rx is online
  assign beat_gate = rx_online_delay ? beat_keep : '0;

  ////////////////////////////////////////
  // Field slicing

  // Plain fields pass straight through
  assign dstrm_state  = rx_word[POS_STATE +: `LPIF_STATE_W];
  assign dstrm_protid = rx_word[POS_PROTID +: `LPIF_PROTID_W];
  assign dstrm_crc    = rx_word[POS_CRC +: `LPIF_CRC_W];

  // Data takes the gen mask only
  assign dstrm_data = rx_word[POS_DATA +: `LPIF_DATA_W] & data_keep;

  // Valid strobes take mask and online gate
  assign dstrm_dvalid    = rx_word[POS_DVALID +: `LPIF_BEAT_W] & beat_gate;
  assign dstrm_crc_valid = rx_word[POS_CRC_VALID +: `LPIF_BEAT_W] & beat_gate;
  assign dstrm_valid     = rx_word[POS_VALID +: `LPIF_BEAT_W] & beat_gate;

endmodule

// File: lpif_lane_map.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Link word to PHY channel mapping
// Tx split with strobe/marker, rx reassembly
////////////////////////////////////////
`include "lpif_consts.svh"

module lpif_lane_map
  import lpif_pkg::*;
(
  input  logic       clk_wr,
  input  logic       rst_n,
  input  link_word_t tx_word,
  input  logic       tx_online_delay,
  input  logic       tx_online,
  input  logic       tx_auto_stb_userbit,
  input  beat_mask_t tx_auto_mrk_userbit,
  output phy_chan_t  tx_phy0,
  output phy_chan_t  tx_phy1,
  input  phy_chan_t  rx_phy0,
  input  phy_chan_t  rx_phy1,
  output link_word_t rx_word
);

  // Payload sits just above the strobe bit
  localparam int PL_LO = `LPIF_STB_BIT + 1;
  localparam int PL_W  = `LPIF_LANE_PAYLOAD_W;

  logic                     stb_bit;
  beat_mask_t               mrk_bits;
  logic [PL_W-1:0]          tx_pl0;
  logic [PL_W-1:0]          tx_pl1;
  phy_chan_t                tx_ch0_d;
  phy_chan_t                tx_ch1_d;
  phy_chan_t                rx_ch0_q;
  phy_chan_t                rx_ch1_q;

  ////////////////////////////////////////
  // Transmit channel build

  // Sync bits only while tx is online
  assign stb_bit  = tx_online & tx_auto_stb_userbit;
  assign mrk_bits = tx_online ? tx_auto_mrk_userbit : '0;

  // Payload held at zero until the z delay runs out
  assign tx_pl0 = tx_online_delay ? tx_word[0 +: PL_W] : '0;
  assign tx_pl1 = tx_online_delay ? tx_word[PL_W +: PL_W] : '0;

  always_comb begin
    tx_ch0_d = '0;
    tx_ch1_d = '0;
    // Low half of the word on channel 0
    tx_ch0_d[PL_LO +: PL_W]      = tx_pl0;
    tx_ch0_d[`LPIF_STB_BIT]      = stb_bit;
    tx_ch0_d[`LPIF_MRK_BIT]      = mrk_bits[0];
    // High half on channel 1, same strobe, own marker
    tx_ch1_d[PL_LO +: PL_W]      = tx_pl1;
    tx_ch1_d[`LPIF_STB_BIT]      = stb_bit;
    tx_ch1_d[`LPIF_MRK_BIT]      = mrk_bits[1];
  end

  // Single register stage toward the PHY
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx_ch0_d;
      tx_phy1 <= tx_ch1_d;
    end
  end

  ////////////////////////////////////////
  // Receive reassembly

  // Capture both channels on the same edge
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_ch0_q <= '0;
      rx_ch1_q <= '0;
    end else begin
      rx_ch0_q <= rx_phy0;
      rx_ch1_q <= rx_phy1;
    end
  end

  // Strobe and marker dropped, payloads rejoined
  assign rx_word = {rx_ch1_q[PL_LO +: PL_W], rx_ch0_q[PL_LO +: PL_W]};

endmodule

// File: lpif_pkg.sv
////////////////////////////////////////
// Shared types for the logic link
////////////////////////////////////////
`include "lpif_consts.svh"

package lpif_pkg;

  // Whole link word, valid bits at the bottom
  typedef logic [`LPIF_WORD_W-1:0] link_word_t;

  // One PHY channel as seen on the pins
  typedef logic [`LPIF_PHY_W-1:0] phy_chan_t;

  // User data field
  typedef logic [`LPIF_DATA_W-1:0] lpif_data_t;

  // CRC field
  typedef logic [`LPIF_CRC_W-1:0] lpif_crc_t;

  // Link state field
  typedef logic [`LPIF_STATE_W-1:0] lpif_state_t;

  // Per half-beat mask
  // used for valid, dvalid, crc_valid and markers
  typedef logic [`LPIF_BEAT_W-1:0] beat_mask_t;

  // Delay setting or running delay count
  typedef logic [`LPIF_DELAY_W-1:0] delay_cnt_t;

endpackage

// File: lpif_txrx_x2_slave_top.sv
`timescale 1ns/1ps
////////////////////////////////////////
// x2 half slave logic link top level
////////////////////////////////////////
`include "lpif_consts.svh"

module lpif_txrx_x2_slave_top
  import lpif_pkg::*;
(
  input  logic                      clk_wr,
  input  logic                      rst_n,

  // Link control levels
  input  logic                      tx_online,
  input  logic                      rx_online,

  // PHY channels
  output phy_chan_t                 tx_phy0,
  output phy_chan_t                 tx_phy1,
  input  phy_chan_t                 rx_phy0,
  input  phy_chan_t                 rx_phy1,

  // Downstream user fields
  output lpif_state_t               dstrm_state,
  output logic [`LPIF_PROTID_W-1:0] dstrm_protid,
  output lpif_data_t                dstrm_data,
  output beat_mask_t                dstrm_dvalid,
  output lpif_crc_t                 dstrm_crc,
  output beat_mask_t                dstrm_crc_valid,
  output beat_mask_t                dstrm_valid,

  // Upstream user fields
  input  lpif_state_t               ustrm_state,
  input  logic [`LPIF_PROTID_W-1:0] ustrm_protid,
  input  lpif_data_t                ustrm_data,
  input  beat_mask_t                ustrm_dvalid,
  input  lpif_crc_t                 ustrm_crc,
  input  beat_mask_t                ustrm_crc_valid,
  input  beat_mask_t                ustrm_valid,

  // Configuration
  input  logic                      m_gen2_mode,
  input  beat_mask_t                tx_mrk_userbit,
  input  logic                      tx_stb_userbit,
  input  delay_cnt_t                delay_x_value,
  input  delay_cnt_t                delay_y_value,
  input  delay_cnt_t                delay_z_value
);

  link_word_t tx_word;
  link_word_t rx_word;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_auto_stb_userbit;
  beat_mask_t tx_auto_mrk_userbit;

  ////////////////////////////////////////
  // Bring-up sequencing

  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  ////////////////////////////////////////
  // Data path, pack -> lanes -> unpack

  lpif_field_pack u_field_pack (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .m_gen2_mode     (m_gen2_mode),
    .tx_word         (tx_word)
  );

  // Only registered stages of the link
  lpif_lane_map u_lane_map (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_word             (tx_word),
    .tx_online_delay     (tx_online_delay),
    .tx_online           (tx_online),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy0             (tx_phy0),
    .tx_phy1             (tx_phy1),
    .rx_phy0             (rx_phy0),
    .rx_phy1             (rx_phy1),
    .rx_word             (rx_word)
  );

  lpif_field_unpack u_field_unpack (
    .rx_word         (rx_word),
    .rx_online_delay (rx_online_delay),
    .m_gen2_mode     (m_gen2_mode),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////
module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk_wr,
  output logic rst_n
);

  // Free running clock
  initial begin
    clk_wr = 1'b0;
    forever #(PERIOD_NS / 2) clk_wr = ~clk_wr;
  end

  // Reset held low for a few edges, released just after one
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_wr);
    #1 rst_n = 1'b1;
  end

endmodule

// File: tb_lpif_top.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Testbench for the x2 half slave link
// PHY loopback, reference model, watchdog
////////////////////////////////////////
`include "lpif_consts.svh"

module tb_lpif_top
  import lpif_pkg::*;
();

  localparam int N_RAND        = 40;
  localparam int LEAD_LIMIT    = 40;
  localparam int TEST_CYCLES   = 4 + 2 + 2 * LEAD_LIMIT + 2 * (N_RAND + 4) + 14;
  localparam int MARGIN_CYCLES = 50;
  localparam int PL_HI         = `LPIF_LANE_PAYLOAD_W;

  // One upstream sample as launched, plus launch conditions
  typedef struct packed {
    logic                      gen2;
    logic                      tx_live;
    lpif_state_t               state;
    logic [`LPIF_PROTID_W-1:0] protid;
    lpif_data_t                data;
    beat_mask_t                dvalid;
    lpif_crc_t                 crc;
    beat_mask_t                crc_valid;
    beat_mask_t                valid;
  } sample_t;

  logic clk_wr, rst_n, tx_online, rx_online, m_gen2_mode, tx_stb_userbit;
  phy_chan_t tx_phy0, tx_phy1, rx_phy0, rx_phy1;
  lpif_state_t ustrm_state, dstrm_state;
  logic [`LPIF_PROTID_W-1:0] ustrm_protid, dstrm_protid;
  lpif_data_t ustrm_data, dstrm_data;
  lpif_crc_t ustrm_crc, dstrm_crc;
  beat_mask_t ustrm_dvalid, ustrm_crc_valid, ustrm_valid, tx_mrk_userbit;
  beat_mask_t dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  delay_cnt_t delay_x_value, delay_y_value, delay_z_value;

  integer seed;
  int num_checks, num_errs;
  delay_cnt_t x_cnt, y_cnt, z_cnt;
  logic tx_live_m, stb_live_m, rx_live_m, prev_stb, prev_live;
  beat_mask_t prev_mrk;
  sample_t pend[$];
  sample_t s_old, s_exp, s_new;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(4)) u_clk_gen (.clk_wr(clk_wr), .rst_n(rst_n));

  lpif_txrx_x2_slave_top uut (.*);

  // External loopback, channel for channel
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  ////////////////////////////////////////
  // Counter model of the delay rule

  always @(posedge clk_wr) begin
    // Low level or reset clears, all ones holds
    if (!rst_n || !tx_online) z_cnt <= '0;
    else if (z_cnt != '1) z_cnt <= z_cnt + 1'b1;
    if (!rst_n || !tx_online) y_cnt <= '0;
    else if (y_cnt != '1) y_cnt <= y_cnt + 1'b1;
    if (!rst_n || !rx_online) x_cnt <= '0;
    else if (x_cnt != '1) x_cnt <= x_cnt + 1'b1;
  end

  assign tx_live_m  = tx_online && (z_cnt >= delay_z_value);
  assign stb_live_m = tx_online && (y_cnt >= delay_y_value);
  assign rx_live_m  = rx_online && (x_cnt >= delay_x_value);

  // Expected downstream view of one launched sample
  function automatic sample_t expect_fields(input sample_t s, input logic gen2_rx,
                                            input logic rx_live);
    sample_t e;
    e = s;
    // Payload was forced to zero on the channels
    if (!s.tx_live) e = '0;
    // Gen1 at either end, lower half and half-beat 0 only
    if (!(s.gen2 && gen2_rx)) begin
      e.data[`LPIF_DATA_W-1:`LPIF_DATA_W/2] = '0;
      e.dvalid[1]    = 1'b0;
      e.crc_valid[1] = 1'b0;
      e.valid[1]     = 1'b0;
    end
    if (!rx_live) begin
      e.dvalid    = '0;
      e.crc_valid = '0;
      e.valid     = '0;
    end
    return e;
  endfunction

  task automatic check_val(input string what, input logic [`LPIF_DATA_W-1:0] got,
                           input logic [`LPIF_DATA_W-1:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errs++;
      $display("ERR at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Cycle by cycle compare at falling edge

  always @(negedge clk_wr) begin
    if (!rst_n) begin
      pend.delete();
      prev_stb  = 1'b0;
      prev_mrk  = '0;
      prev_live = 1'b0;
    end else begin
      // Sync bits registered from last cycle
      check_val("tx_phy0 strobe", tx_phy0[`LPIF_STB_BIT], prev_stb);
      check_val("tx_phy1 strobe", tx_phy1[`LPIF_STB_BIT], prev_stb);
      check_val("tx_phy0 marker", tx_phy0[`LPIF_MRK_BIT], prev_mrk[0]);
      check_val("tx_phy1 marker", tx_phy1[`LPIF_MRK_BIT], prev_mrk[1]);
      if (!prev_live) begin
        check_val("tx_phy0 idle payload", tx_phy0[PL_HI:1], '0);
        check_val("tx_phy1 idle payload", tx_phy1[PL_HI:1], '0);
      end
      // Two edges from upstream to downstream
      if (pend.size() == 2) begin
        s_old = pend.pop_front();
        s_exp = expect_fields(s_old, m_gen2_mode, rx_live_m);
        check_val("dstrm_state", dstrm_state, s_exp.state);
        check_val("dstrm_protid", dstrm_protid, s_exp.protid);
        check_val("dstrm_data", dstrm_data, s_exp.data);
        check_val("dstrm_dvalid", dstrm_dvalid, s_exp.dvalid);
        check_val("dstrm_crc", dstrm_crc, s_exp.crc);
        check_val("dstrm_crc_valid", dstrm_crc_valid, s_exp.crc_valid);
        check_val("dstrm_valid", dstrm_valid, s_exp.valid);
      end
      s_new = {m_gen2_mode, tx_live_m, ustrm_state, ustrm_protid, ustrm_data,
               ustrm_dvalid, ustrm_crc, ustrm_crc_valid, ustrm_valid};
      pend.push_back(s_new);
      prev_stb  = stb_live_m & tx_stb_userbit;
      prev_mrk  = tx_online ? tx_mrk_userbit : '0;
      prev_live = tx_live_m;
    end
  end

  ////////////////////////////////////////
  // Stimulus and tests

  task automatic drive_random;
    ustrm_state     = $random(seed);
    ustrm_protid    = $random(seed);
    ustrm_data      = {$random(seed), $random(seed), $random(seed), $random(seed)};
    ustrm_dvalid    = $random(seed);
    ustrm_crc       = $random(seed);
    ustrm_crc_valid = $random(seed);
    ustrm_valid     = $random(seed);
    tx_mrk_userbit  = $random(seed);
    tx_stb_userbit  = $random(seed);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    $display("test %s finished, %0d errors", name, num_errs - errs_at_start);
  endtask

  task automatic check_after_reset;
    int errs0;
    errs0 = num_errs;
    wait (rst_n === 1'b1);
    @(negedge clk_wr);
    check_val("tx_phy0 after reset", tx_phy0, '0);
    check_val("tx_phy1 after reset", tx_phy1, '0);
    check_val("dstrm valid bits after reset", {dstrm_valid, dstrm_dvalid, dstrm_crc_valid}, '0);
    report_test("reset state", errs0);
  endtask

  // Marker, strobe and payload leads, then the rx gate
  task automatic run_bringup;
    int errs0;
    int n;
    int got_mrk;
    int got_stb;
    int got_pl;
    errs0   = num_errs;
    got_mrk = -1;
    got_stb = -1;
    got_pl  = -1;
    @(posedge clk_wr);
    #1;
    drive_random();
    {ustrm_valid, ustrm_dvalid, ustrm_crc_valid} = '1;
    tx_mrk_userbit = 2'b11;
    tx_stb_userbit = 1'b1;
    tx_online      = 1'b1;
    n = 0;
    @(negedge clk_wr);
    while (got_pl < 0 && n < LEAD_LIMIT) begin
      if (got_mrk < 0 && tx_phy0[`LPIF_MRK_BIT] && tx_phy1[`LPIF_MRK_BIT]) got_mrk = n;
      if (got_stb < 0 && tx_phy0[`LPIF_STB_BIT]) got_stb = n;
      if (tx_phy0[PL_HI:1] != '0) got_pl = n;
      n++;
      @(negedge clk_wr);
    end
    // Each lead is its delay plus the tx register
    check_val("marker lead", got_mrk, 1);
    check_val("strobe lead", got_stb, delay_y_value + 1);
    check_val("payload lead", got_pl, delay_z_value + 1);
    @(posedge clk_wr);
    #1 rx_online = 1'b1;
    n = 0;
    @(negedge clk_wr);
    while (dstrm_valid == '0 && n < LEAD_LIMIT) begin
      n++;
      @(negedge clk_wr);
    end
    check_val("rx gate lead", n, delay_x_value);
    report_test("bring-up timing", errs0);
  endtask

  task automatic run_traffic(input logic gen2, input string name);
    int errs0;
    errs0 = num_errs;
    for (int i = 0; i < N_RAND; i++) begin
      @(posedge clk_wr);
      #1;
      m_gen2_mode = gen2;
      drive_random();
    end
    repeat (3) @(negedge clk_wr);
    report_test(name, errs0);
  endtask

  task automatic drop_tx_online;
    int errs0;
    errs0 = num_errs;
    repeat (6) begin
      @(posedge clk_wr);
      #1 drive_random();
    end
    @(posedge clk_wr);
    #1 tx_online = 1'b0;
    // Pins still carry the last online cycle
    @(negedge clk_wr);
    @(negedge clk_wr);
    check_val("tx_phy0 after drop", tx_phy0, '0);
    check_val("tx_phy1 after drop", tx_phy1, '0);
    @(negedge clk_wr);
    check_val("dstrm_valid after drop", dstrm_valid, '0);
    repeat (2) @(negedge clk_wr);
    report_test("tx offline", errs0);
  endtask

  initial begin
    seed            = 18365;
    num_checks      = 0;
    num_errs        = 0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    m_gen2_mode     = 1'b1;
    tx_mrk_userbit  = '0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = 16'd5;
    delay_y_value   = 16'd3;
    delay_z_value   = 16'd7;
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid} = '0;
    {ustrm_crc, ustrm_crc_valid, ustrm_valid} = '0;
    check_after_reset();
    run_bringup();
    run_traffic(1'b1, "gen2 traffic");
    run_traffic(1'b0, "gen1 traffic");
    drop_tx_online();
    $display("checks %0d, errors %0d", num_checks, num_errs);
    if (num_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * 10);
    $display("Timeout: the run did not finish within %0d cycles",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
